// File: io_pkg.sv
`default_nettype none

package io_pkg;

  // ==============================
  // Address decode
  // ==============================
  localparam int SEL_LSB = 29;        // Selector sits in address[31:29]

  typedef enum logic [2:0] {
    SEL_PORT  = 3'd0,
    SEL_UART  = 3'd1,
    SEL_TIMER = 3'd3,
    SEL_DAC1  = 3'd5,
    SEL_DAC2  = 3'd6
  } io_sel_t;                         // Codes 2 and 4 unused

  typedef logic [4:0] dac_code_t;

  // ==============================
  // Write data views
  // ==============================
  typedef union packed {
    logic [7:0] value;                // UART byte
    struct packed {
      logic [2:0] spare;
      dac_code_t  dac_code;
    } dac;
  } io_byte_u;

  typedef union packed {
    logic [31:0] raw;                 // Timer load value
    struct packed {
      logic [29:0] spare;
      logic        irq_clear;
      logic        led;
    } port;
    struct packed {
      logic [23:0] spare;
      io_byte_u    data;
    } code;
  } io_wdata_u;

  typedef struct packed {
    logic        req;
    logic        nwr;                 // High for a read
    logic [31:0] address;
    io_wdata_u   wdata;
  } io_req_t;

  typedef struct packed {
    logic [26:0] zero;
    logic        button1;
    logic        button2;
    logic        timer_irq;
    logic        uart_busy;
    logic        uart_full;
  } io_status_t;

endpackage

`default_nettype wire

// File: io_decoder.sv
`timescale 1ns/1ps
`default_nettype none

module io_decoder (
  input  wire                clk,
  input  wire                rst,
  input  wire io_pkg::io_req_t    bus,
  input  wire io_pkg::io_status_t status,
  input  wire                uart_accept,
  output logic               port_wr,
  output logic               dac1_wr,
  output logic               dac2_wr,
  output logic               timer_wr,
  output logic               uart_wr,
  output logic [31:0]        rdata,
  output logic               io_ready
);
  import io_pkg::*;

  io_sel_t sel;
  logic    pending;
  logic    write;
  logic    accept;

  assign sel = io_sel_t'(bus.address[31:SEL_LSB]);

  // Request still open, the ready cycle itself is not a new access
  assign pending = bus.req & ~io_ready;
  assign write   = pending & ~bus.nwr;

  // ==============================
  // Write strobes
  // ==============================
  always_comb begin
    port_wr  = 1'b0;
    dac1_wr  = 1'b0;
    dac2_wr  = 1'b0;
    timer_wr = 1'b0;
    uart_wr  = 1'b0;
    if (write) begin
      case (sel)
        SEL_PORT:  port_wr  = 1'b1;
        SEL_UART:  uart_wr  = 1'b1;
        SEL_TIMER: timer_wr = 1'b1;
        SEL_DAC1:  dac1_wr  = 1'b1;
        SEL_DAC2:  dac2_wr  = 1'b1;
        default:   ;                  // Unused codes just complete
      endcase
    end
  end

  // Only the UART can hold off a write
  assign accept = uart_wr ? uart_accept : pending;

  // ==============================
  // Read data and ready
  // ==============================
  always_comb begin
    if (bus.nwr && sel == SEL_PORT) begin
      rdata = status;
    end else begin
      rdata = 32'h0;                  // UART data and the rest read zero
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      io_ready <= 1'b0;
    end else begin
      io_ready <= accept;             // One cycle pulse per access
    end
  end

endmodule

`default_nettype wire

// File: io_regs.sv
`timescale 1ns/1ps
`default_nettype none

module io_regs (
  input  wire                   clk,
  input  wire                   rst,
  input  wire io_pkg::io_wdata_u wdata,
  input  wire                   port_wr,
  input  wire                   dac1_wr,
  input  wire                   dac2_wr,
  output logic                  led,
  output logic                  irq_ack,
  output io_pkg::dac_code_t     dac1_code,
  output io_pkg::dac_code_t     dac2_code
);
  import io_pkg::*;

  dac_code_t new_code;

  assign new_code = wdata.code.data.dac.dac_code;

  // ==============================
  // Output port
  // ==============================
  always_ff @(posedge clk) begin
    if (rst) begin
      led     <= 1'b0;
      irq_ack <= 1'b0;
    end else begin
      irq_ack <= port_wr & wdata.port.irq_clear;   // Pulse, not a level
      if (port_wr) begin
        led <= wdata.port.led;
      end
    end
  end

  // ==============================
  // DAC codes
  // ==============================
  always_ff @(posedge clk) begin
    if (rst) begin
      dac1_code <= '0;
      dac2_code <= '0;
    end else begin
      if (dac1_wr) begin
        dac1_code <= new_code;
      end
      if (dac2_wr) begin
        dac2_code <= new_code;
      end
    end
  end

endmodule

`default_nettype wire

// File: interval_timer.sv
`timescale 1ns/1ps
`default_nettype none

module interval_timer #(
  parameter int TIMER_PRESCALE = 32,
  parameter int TIMER_BITS     = 16
) (
  input  wire        clk,
  input  wire        rst,
  input  wire [31:0] value,
  input  wire        load,
  input  wire        irq_ack,
  output logic       irq
);
  localparam int PRE_BITS = (TIMER_PRESCALE > 1) ? $clog2(TIMER_PRESCALE) : 1;

  logic [PRE_BITS-1:0]   pre;
  logic [TIMER_BITS-1:0] count;
  logic                  tick;
  logic                  expire;

  assign tick   = (pre == PRE_BITS'(TIMER_PRESCALE - 1));
  assign expire = ~load & tick & (count == TIMER_BITS'(1));

  // ==============================
  // Prescaler and countdown
  // ==============================
  always_ff @(posedge clk) begin
    if (rst) begin
      pre   <= '0;
      count <= '0;
    end else if (load) begin
      pre   <= '0;                          // Restart the period too
      count <= value[TIMER_BITS-1:0];       // Zero leaves the timer stopped
    end else if (count != '0) begin
      if (tick) begin
        pre   <= '0;
        count <= count - 1'b1;
      end else begin
        pre <= pre + 1'b1;
      end
    end
  end

  // Held until acknowledged, a fresh expiry wins over the ack
  always_ff @(posedge clk) begin
    if (rst) begin
      irq <= 1'b0;
    end else begin
      irq <= expire | (irq & ~irq_ack);
    end
  end

endmodule

`default_nettype wire

// File: uart_tx_fifo.sv
`timescale 1ns/1ps
`default_nettype none

module uart_tx_fifo #(
  parameter int UART_CLOCK_DIV = 234,
  parameter int FIFO_BITS      = 4
) (
  input  wire       clk,
  input  wire       rst,
  input  wire [7:0] data,
  input  wire       wr,
  output logic      accept,
  output logic      full,
  output logic      busy,
  output logic      tx
);
  localparam int DEPTH    = 1 << FIFO_BITS;
  localparam int DIV_BITS = (UART_CLOCK_DIV > 1) ? $clog2(UART_CLOCK_DIV) : 1;

  logic [7:0]         mem [DEPTH];
  logic [FIFO_BITS:0] wr_ptr;
  logic [FIFO_BITS:0] rd_ptr;
  logic               empty;
  logic               pop;

  logic [9:0]          shift;
  logic [3:0]          bit_cnt;
  logic [DIV_BITS-1:0] div;
  logic                sending;

  // ==============================
  // Write FIFO
  // ==============================
  assign empty  = (wr_ptr == rd_ptr);
  assign full   = (wr_ptr[FIFO_BITS] != rd_ptr[FIFO_BITS]) &&
                  (wr_ptr[FIFO_BITS-1:0] == rd_ptr[FIFO_BITS-1:0]);
  assign accept = wr & ~full;
  assign pop    = ~sending & ~empty;     // Next byte once the line is idle

  always_ff @(posedge clk) begin
    if (accept) begin
      mem[wr_ptr[FIFO_BITS-1:0]] <= data;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
    end else begin
      if (accept) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (pop) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
    end
  end

  // ==============================
  // Serializer
  // ==============================
  always_ff @(posedge clk) begin
    if (pop) begin
      shift <= {1'b1, mem[rd_ptr[FIFO_BITS-1:0]], 1'b0};   // Stop, data, start
    end else if (sending && div == DIV_BITS'(UART_CLOCK_DIV - 1)) begin
      shift <= {1'b1, shift[9:1]};       // LSB first
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      sending <= 1'b0;
      bit_cnt <= '0;
      div     <= '0;
    end else if (pop) begin
      sending <= 1'b1;
      bit_cnt <= '0;
      div     <= '0;
    end else if (sending) begin
      if (div == DIV_BITS'(UART_CLOCK_DIV - 1)) begin
        div <= '0;
        if (bit_cnt == 4'd9) begin
          sending <= 1'b0;               // Stop bit done
        end else begin
          bit_cnt <= bit_cnt + 1'b1;
        end
      end else begin
        div <= div + 1'b1;
      end
    end
  end

  assign tx   = ~sending | shift[0];     // Line idles high
  assign busy = sending | ~empty;

endmodule

`default_nettype wire

// File: io_top.sv
`timescale 1ns/1ps
`default_nettype none

module io_top #(
  parameter int UART_CLOCK_DIV = 234,
  parameter int FIFO_BITS      = 4,
  parameter int TIMER_PRESCALE = 32,
  parameter int TIMER_BITS     = 16
) (
  input  wire                  clk,
  input  wire                  rst,
  input  wire io_pkg::io_req_t bus,
  output logic [31:0]          rdata,
  output logic                 io_ready,
  input  wire                  button1,
  input  wire                  button2,
  output logic                 led,
  output io_pkg::dac_code_t    dac1_code,
  output io_pkg::dac_code_t    dac2_code,
  output logic                 timer_irq,
  output logic                 tx
);
  import io_pkg::*;

  io_status_t status;
  logic       port_wr;
  logic       dac1_wr;
  logic       dac2_wr;
  logic       timer_wr;
  logic       uart_wr;
  logic       uart_accept;
  logic       uart_full;
  logic       uart_busy;
  logic       irq_ack;

  assign status = '{zero: '0, button1: button1, button2: button2,
                    timer_irq: timer_irq, uart_busy: uart_busy, uart_full: uart_full};

  io_decoder u_decoder (
    .clk(clk), .rst(rst), .bus(bus), .status(status), .uart_accept(uart_accept),
    .port_wr(port_wr), .dac1_wr(dac1_wr), .dac2_wr(dac2_wr), .timer_wr(timer_wr),
    .uart_wr(uart_wr), .rdata(rdata), .io_ready(io_ready)
  );

  io_regs u_regs (
    .clk(clk), .rst(rst), .wdata(bus.wdata),
    .port_wr(port_wr), .dac1_wr(dac1_wr), .dac2_wr(dac2_wr),
    .led(led), .irq_ack(irq_ack), .dac1_code(dac1_code), .dac2_code(dac2_code)
  );

  interval_timer #(
    .TIMER_PRESCALE(TIMER_PRESCALE),
    .TIMER_BITS(TIMER_BITS)
  ) u_timer (
    .clk(clk), .rst(rst), .value(bus.wdata.raw), .load(timer_wr),
    .irq_ack(irq_ack), .irq(timer_irq)
  );

  uart_tx_fifo #(
    .UART_CLOCK_DIV(UART_CLOCK_DIV),
    .FIFO_BITS(FIFO_BITS)
  ) u_uart (
    .clk(clk), .rst(rst), .data(bus.wdata.code.data.value), .wr(uart_wr),
    .accept(uart_accept), .full(uart_full), .busy(uart_busy), .tx(tx)
  );

endmodule

`default_nettype wire

// File: tb_io_top.sv
`timescale 1ns/1ps
`default_nettype none

module tb_io_top;
  import io_pkg::*;

  localparam int UART_CLOCK_DIV = 8;
  localparam int BUS_TIMEOUT    = 300;
  localparam int BYTE_TIMEOUT   = 400;

  logic        clk;
  logic        rst;
  io_req_t     bus;
  logic [31:0] rdata;
  logic        io_ready;
  logic        button1;
  logic        button2;
  logic        led;
  dac_code_t   dac1_code;
  dac_code_t   dac2_code;
  logic        timer_irq;
  logic        tx;

  int          errors;
  int          tests;
  logic [31:0] rand_state;
  logic [7:0]  rx_bytes[$];           // Decoded from tx
  logic [7:0]  burst_bytes[$];        // Random bytes still to arrive

  io_top #(
    .UART_CLOCK_DIV(UART_CLOCK_DIV), .FIFO_BITS(2), .TIMER_PRESCALE(4), .TIMER_BITS(16)
  ) DUT (
    .clk(clk), .rst(rst), .bus(bus), .rdata(rdata), .io_ready(io_ready),
    .button1(button1), .button2(button2), .led(led), .dac1_code(dac1_code),
    .dac2_code(dac2_code), .timer_irq(timer_irq), .tx(tx)
  );

  always #2 clk = ~clk;

  // ==============================
  // Compare tasks
  // ==============================
  task automatic check_word(input string name, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
      $display("MISMATCH at %0t ns: %s got %h expected %h", $time, name, got, exp);
      errors++;
    end
  endtask

  task automatic check_dac(input string name, input dac_code_t got, input dac_code_t exp);
    if (got !== exp) begin
      $display("MISMATCH at %0t ns: %s got %h expected %h", $time, name, got, exp);
      errors++;
    end
  endtask

  task automatic check_byte(input string name, input logic [7:0] got, input logic [7:0] exp);
    if (got !== exp) begin
      $display("MISMATCH at %0t ns: %s got %h expected %h", $time, name, got, exp);
      errors++;
    end
  endtask

  task automatic check_bit(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      $display("MISMATCH at %0t ns: %s got %b expected %b", $time, name, got, exp);
      errors++;
    end
  endtask

  function automatic logic [31:0] lcg_next(input logic [31:0] state);
    return state * 32'd1664525 + 32'd1013904223;
  endfunction

  // ==============================
  // Bus and line helpers
  // ==============================
  task automatic bus_access(input logic nwr, input logic [2:0] sel, input logic [31:0] data,
                            output logic [31:0] word, output int latency);
    int n;
    bit done;
    n = 0;
    done = 1'b0;
    word = '0;
    @(negedge clk);
    bus.req = 1'b1;
    bus.nwr = nwr;
    bus.address = {sel, 29'h0};
    bus.wdata.raw = data;
    while (!done && n < BUS_TIMEOUT) begin
      @(negedge clk);
      n++;
      if (io_ready) begin
        word = rdata;                 // Valid with the ready pulse
        done = 1'b1;
      end
    end
    bus.req = 1'b0;
    latency = done ? n : -1;
    if (!done) begin
      $display("Timeout: no io_ready within %0d cycles for selector %0d", BUS_TIMEOUT, sel);
      errors++;
    end
  endtask

  task automatic wait_byte(output logic [7:0] value, output bit found);
    int n;
    n = 0;
    found = 1'b0;
    value = '0;
    while (!found && n < BYTE_TIMEOUT) begin
      if (rx_bytes.size() > 0) begin
        value = rx_bytes.pop_front();
        found = 1'b1;
      end else begin
        @(negedge clk);
        n++;
      end
    end
    if (!found) begin
      $display("Timeout: no byte seen on tx within %0d cycles", BYTE_TIMEOUT);
      errors++;
    end
  endtask

  // Interrupt must rise exactly at first_cycle, 0 means never within the window
  task automatic watch_irq(input int window, input int first_cycle);
    int   k;
    logic want;
    bit   stop;
    k = 0;
    stop = 1'b0;
    while (!stop && k < window) begin
      @(negedge clk);
      k++;
      want = (first_cycle != 0) && (k >= first_cycle);
      if (timer_irq !== want || want) begin
        check_bit("timer_irq", timer_irq, want);
        stop = 1'b1;
      end
    end
    if (!stop && first_cycle != 0) begin
      $display("Timeout: timer_irq did not rise within %0d cycles", window);
      errors++;
    end
  endtask

  task automatic check_pin(input logic [7:0] pin, input logic [31:0] expected);
    @(negedge clk);
    case (pin)
      8'd0: check_bit("led", led, expected[0]);
      8'd1: check_bit("timer_irq", timer_irq, expected[0]);
      8'd2: check_bit("tx", tx, expected[0]);
      8'd5: check_dac("dac1_code", dac1_code, expected[4:0]);
      8'd6: check_dac("dac2_code", dac2_code, expected[4:0]);
      default: begin
        $display("Data file names unknown pin %0d", pin);
        errors++;
      end
    endcase
  endtask

  // ==============================
  // Serial line decoder
  // ==============================
  always begin : serial_monitor
    logic [7:0] value;
    @(negedge clk);
    if (!rst && tx === 1'b0) begin
      repeat (UART_CLOCK_DIV / 2) @(negedge clk);   // Middle of the start bit
      if (tx !== 1'b0) begin
        $display("Start bit on tx ended early at %0t ns", $time);
        errors++;
      end else begin
        for (int i = 0; i < 8; i++) begin
          repeat (UART_CLOCK_DIV) @(negedge clk);
          value[i] = tx;
        end
        repeat (UART_CLOCK_DIV) @(negedge clk);
        check_bit("tx stop bit", tx, 1'b1);
        rx_bytes.push_back(value);
      end
    end
  end

  // ==============================
  // Main sequence
  // ==============================
  initial begin : main
    int          fd;
    int          fields;
    int          latency;
    int          errors_before;
    string       line;
    logic [7:0]  op;
    logic [7:0]  sel;
    logic [31:0] data;
    logic [31:0] expected;
    logic [31:0] word;
    logic [7:0]  value;
    bit          found;

    $timeformat(-9, 0, "", 0);        // Times print as whole ns
    clk = 1'b0;
    rst = 1'b1;
    bus = '0;
    button1 = 1'b1;
    button2 = 1'b0;
    errors = 0;
    tests = 0;
    rand_state = 32'he6ab5624;
    repeat (16) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;

    fd = $fopen("io_input.txt", "r");
    if (fd == 0) begin
      $display("Cannot open io_input.txt");
      errors++;
    end else begin
      while (!$feof(fd)) begin
        fields = 0;
        line = "";
        if ($fgets(line, fd) > 0 && line.getc(0) != "#") begin
          fields = $sscanf(line, "%h %h %h %h", op, sel, data, expected);
        end
        if (fields == 4) begin
          tests++;
          errors_before = errors;
          case (op)
            8'h0, 8'h1: begin                           // Write, read
              bus_access(op[0], sel[2:0], data, word, latency);
              if (op[0]) check_word("rdata", word, expected);
              if (latency >= 0) check_word("io_ready latency", 32'(latency), 32'd1);
            end
            8'h2: begin                                 // Serial check
              wait_byte(value, found);
              if (found) check_byte("tx byte", value, expected[7:0]);
            end
            8'h3: watch_irq(int'(data), int'(expected));
            8'h4: check_pin(sel, expected);
            8'h5: begin                                 // Random burst to the UART
              for (int i = 0; i < int'(data); i++) begin
                rand_state = lcg_next(rand_state);
                burst_bytes.push_back(rand_state[23:16]);
                bus_access(1'b0, SEL_UART, {24'h0, rand_state[23:16]}, word, latency);
              end
            end
            8'h6: begin                                 // Burst bytes in order
              for (int i = 0; i < int'(data) && burst_bytes.size() > 0; i++) begin
                wait_byte(value, found);
                if (found) check_byte("tx burst byte", value, burst_bytes.pop_front());
              end
            end
            default: begin
              $display("Data file holds unknown operation %0h", op);
              errors++;
            end
          endcase
          $display("Test %0d op %0h sel %0h: %s", tests, op, sel,
                   (errors == errors_before) ? "ok" : "FAILED");
        end
      end
      $fclose(fd);
    end

    $display("%0d tests run, %0d errors", tests, errors);
    if (errors == 0 && tests > 0) begin
      $display("All tests passed");
    end else begin
      $display("Some tests failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: io_input.txt
# op sel data expected, all hex. op 0 write, 1 read, 2 serial byte, 3 irq watch
# (data window, expected first cycle or 0), 4 pin (0 led 1 irq 2 tx 5/6 dac), 5 burst, 6 burst check
4 0 00000000 00000000
4 5 00000000 00000000
4 6 00000000 00000000
4 2 00000000 00000001
4 1 00000000 00000000
1 0 00000000 00000010
0 5 0000003A 00000000
4 5 00000000 0000001A
0 6 00000127 00000000
4 6 00000000 00000007
4 5 00000000 0000001A
0 0 00000001 00000000
4 0 00000000 00000001
1 1 00000000 00000000
1 2 00000000 00000000
0 3 00000005 00000000
3 0 00000018 00000014
4 1 00000000 00000001
0 0 00000002 00000000
4 1 00000000 00000000
4 0 00000000 00000000
0 3 00000000 00000000
3 0 00000064 00000000
0 1 000000A5 00000000
2 1 00000000 000000A5
0 1 0000013C 00000000
2 1 00000000 0000003C
5 1 00000005 00000000
1 0 00000000 00000013
5 1 00000001 00000000
6 1 00000006 00000000

// File: compile.f
io_pkg.sv
io_decoder.sv
io_regs.sv
interval_timer.sv
uart_tx_fifo.sv
io_top.sv
tb_io_top.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the I/O subsystem testbench, pass only if the log says so
cd "$(dirname "$0")" &&
rm -rf obj_dir sim.log &&
verilator --binary --timing -Wno-fatal -f compile.f --top-module tb_io_top -o tb_io_top &&
./obj_dir/tb_io_top > sim.log 2>&1 ||
echo "Build or run stopped early"
cat sim.log 2>/dev/null
grep -q "^All tests passed$" sim.log 2>/dev/null && echo "PASS" || { echo "FAIL"; exit 1; }
